// File: list.f
+incdir+source
source/opq_elem_pkg.sv
source/opq_cmd_pkg.sv
source/opq_fifo.sv
source/opq_input_stage.sv
source/opq_convert.sv
source/opq_sequencer.sv
source/operand_queue.sv
testbench/tb_operand_queue.sv

// File: run.sh
#!/bin/sh
# Build and run the operand queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_operand_queue -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: testbench/tb_operand_queue.sv
// Word and credit model assume a 64-bit word and a buffer depth of at least 2; fp data is normal only
`include "opq_defines.svh"

module tb_operand_queue
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  // Issued words per test: pass-through, extension, reduction, fp, credit
  localparam int WORDS_TOTAL = 4 + 24 + 64 + 8 + 6;
  localparam int CYCLE_LIMIT = 40 * WORDS_TOTAL + 200;

  // One expected transfer toward the unit
  typedef struct packed {
    word_t      word;
    target_fu_e fu;
    logic       pops;
  } xfer_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic [`OPQ_LANE_W-1:0] lane_id_i;
  opq_cmd_t               cmd_i;
  logic                   cmd_valid_i;
  logic                   operand_queue_ready_o;
  word_t                  operand_i;
  logic                   operand_valid_i;
  logic                   operand_issued_i;
  word_t                  operand_o;
  target_fu_e             target_fu_o;
  logic                   operand_valid_o;
  logic                   operand_ready_i;

  int         seed = 32'h9a43;
  int         errors, tests_run, tests_failed, cycles, usage;
  logic       bp_en, unexpected, exp_ready, pend_inc, pend_dec;
  xfer_t      exp_q[$];
  xfer_t      cur;
  word_t      exp_word;
  target_fu_e exp_fu;

  operand_queue operand_queue_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .lane_id_i             (lane_id_i),
    .cmd_i                 (cmd_i),
    .cmd_valid_i           (cmd_valid_i),
    .operand_queue_ready_o (operand_queue_ready_o),
    .operand_i             (operand_i),
    .operand_valid_i       (operand_valid_i),
    .operand_issued_i      (operand_issued_i),
    .operand_o             (operand_o),
    .target_fu_o           (target_fu_o),
    .operand_valid_o       (operand_valid_o),
    .operand_ready_i       (operand_ready_i)
  );

  always #10 clk_i = ~clk_i;

  // Unit back-pressure, random while enabled
  always @(posedge clk_i) begin
    #2;
    operand_ready_i = bp_en ? 1'($random(seed)) : 1'b1;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic int widen_factor(conv_e conv);
    int f;
    case (conv)
      SExt2, ZExt2, WideFP2: f = 2;
      SExt4, ZExt4:          f = 4;
      SExt8, ZExt8:          f = 8;
      default:               f = 1;
    endcase
    return f;
  endfunction

  function automatic word_t expected_word(opq_cmd_t cmd, word_t w, int pass, int lane);
    word_t res, elem, neutral, emask, dmask;
    int    ew, dw, n;
    fp16_t h16;
    fp32_t s32;
    fp64_t d64;
    ew    = 8 << cmd.eew;
    dw    = ew * widen_factor(cmd.conv);
    n     = 64 / dw;
    emask = (ew == 64) ? '1 : (64'd1 << ew) - 64'd1;
    dmask = (dw == 64) ? '1 : (64'd1 << dw) - 64'd1;
    res   = '0;
    case (cmd.conv)
      SExt2, SExt4, SExt8, ZExt2, ZExt4, ZExt8: begin
        for (int i = 0; i < n; i++) begin
          elem = (w >> ((pass * n + i) * ew)) & emask;
          if ((cmd.conv inside {SExt2, SExt4, SExt8}) && elem[ew-1]) begin
            elem = elem | ~emask;
          end
          res = res | ((elem & dmask) << (i * dw));
        end
      end
      IntRedZExt: begin
        neutral         = cmd.ntr_red[0] ? emask : '0;
        neutral[ew-1]   = cmd.ntr_red[1];
        for (int i = 0; i < 64 / ew; i++) begin
          res = res | (neutral << (i * ew));
        end
        if (lane == 0) begin
          res = (res & ~emask) | (w & emask);
        end
      end
      WideFP2: begin
        if (cmd.eew == EW16) begin
          for (int e = 0; e < 2; e++) begin
            h16   = w[(2 * pass + e) * 16 +: 16];
            s32.s = h16.s;
            s32.e = 8'(h16.e) + 8'(127 - 15);
            s32.m = {h16.m, 13'd0};
            res[e * 32 +: 32] = s32;
          end
        end else begin
          s32   = w[pass * 32 +: 32];
          d64.s = s32.s;
          d64.e = 11'(s32.e) + 11'(1023 - 127);
          d64.m = {s32.m, 29'd0};
          res   = d64;
        end
      end
      default: res = w;
    endcase
    return res;
  endfunction

  // Random word; fp exponents avoid zero and all ones
  function automatic word_t new_word(opq_cmd_t cmd);
    word_t w;
    fp16_t h16;
    fp32_t s32;
    w = {$random(seed), $random(seed)};
    if (cmd.conv == WideFP2 && cmd.eew == EW16) begin
      for (int k = 0; k < 4; k++) begin
        h16   = w[k * 16 +: 16];
        h16.e = 5'(1 + {$random(seed)} % 30);
        w[k * 16 +: 16] = h16;
      end
    end else if (cmd.conv == WideFP2) begin
      for (int k = 0; k < 2; k++) begin
        s32   = w[k * 32 +: 32];
        s32.e = 8'(1 + {$random(seed)} % 254);
        w[k * 32 +: 32] = s32;
      end
    end
    return w;
  endfunction

  function automatic opq_cmd_t make_cmd(conv_e conv, eew_e eew, logic [1:0] ntr,
                                        target_fu_e fu, logic [`OPQ_VL_W-1:0] vl);
    opq_cmd_t cmd;
    cmd.conv      = conv;
    cmd.eew       = eew;
    cmd.ntr_red   = ntr;
    cmd.target_fu = fu;
    cmd.vl        = vl;
    return cmd;
  endfunction

  ////////////////////
  // Drivers
  ////////////////////

  task automatic push_cmd(opq_cmd_t cmd);
    cmd_i       = cmd;
    cmd_valid_i = 1'b1;
    @(posedge clk_i);
    #2 cmd_valid_i = 1'b0;
  endtask

  task automatic issue_pulse();
    operand_issued_i = 1'b1;
    @(posedge clk_i);
    #2 operand_issued_i = 1'b0;
  endtask

  // Waits for a credit first when the read is issued with the word
  task automatic send_word(word_t w, logic issue);
    while (issue && !operand_queue_ready_o) begin
      @(posedge clk_i);
      #2;
    end
    operand_i        = w;
    operand_valid_i  = 1'b1;
    operand_issued_i = issue;
    @(posedge clk_i);
    #2;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
  endtask

  // Queue the expected transfers of a command, then push it and its words
  task automatic run_cmd(opq_cmd_t cmd);
    word_t words[$];
    word_t w;
    xfer_t x;
    int    f, n, cnt, pass;
    logic  done;
    f    = widen_factor(cmd.conv);
    n    = (cmd.conv == IntRedZExt) ? 1 : 64 / ((8 << cmd.eew) * f);
    cnt  = 0;
    pass = 0;
    done = 1'b0;
    w    = new_word(cmd);
    words.push_back(w);
    while (!done) begin
      cnt    = cnt + n;
      done   = (cnt >= int'(cmd.vl));
      x.word = expected_word(cmd, w, pass, int'(lane_id_i));
      x.fu   = cmd.target_fu;
      x.pops = done || (pass == f - 1);
      exp_q.push_back(x);
      if (!done && pass == f - 1) begin
        pass = 0;
        w    = new_word(cmd);
        words.push_back(w);
      end else begin
        pass = pass + 1;
      end
    end
    push_cmd(cmd);
    foreach (words[i]) begin
      send_word(words[i], 1'b1);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 100) begin
      @(posedge clk_i);
      #2 waited++;
    end
    @(posedge clk_i);
    #2;
    assert (exp_q.size() == 0)
      else report_failure($sformatf("%0d expected transfers never came", exp_q.size()));
    assert (!operand_valid_o) else report_failure("output still valid after the last transfer");
  endtask

  ////////////////////
  // Checking
  ////////////////////

  task automatic value_mismatch(string name, word_t got, word_t exp);
    $display("Mismatch at %0d ns: %s got %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_failure(string msg);
    $display("Error at %0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(string name, int err_before);
    tests_run++;
    if (errors > err_before) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err_before);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // Next edge's transfer and credit events are settled at the falling edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      usage      = 0;
      pend_inc   = 1'b0;
      pend_dec   = 1'b0;
      exp_ready  = 1'b1;
      unexpected = 1'b0;
    end else begin
      usage      = usage + int'(pend_inc) - int'(pend_dec);
      exp_ready  = (usage < `OPQ_BUF_DEPTH);
      pend_inc   = operand_issued_i;
      pend_dec   = 1'b0;
      unexpected = 1'b0;
      if (operand_valid_o && operand_ready_i) begin
        if (exp_q.size() == 0) begin
          unexpected = 1'b1;
        end else begin
          cur      = exp_q.pop_front();
          exp_word = cur.word;
          exp_fu   = cur.fu;
          pend_dec = cur.pops;
        end
      end
    end
  end

  a_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_valid_o && operand_ready_i) |-> (operand_o == exp_word))
    else value_mismatch("operand_o", $sampled(operand_o), exp_word);

  a_fu: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_valid_o && operand_ready_i) |-> (target_fu_o == exp_fu))
    else value_mismatch("target_fu_o", 64'($sampled(target_fu_o)), 64'(exp_fu));

  a_extra: assert property (@(posedge clk_i) disable iff (!rst_ni) !unexpected)
    else report_failure("transfer with no expected word");

  a_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_queue_ready_o == exp_ready)
    else value_mismatch("operand_queue_ready_o", 64'($sampled(operand_queue_ready_o)),
                        64'(exp_ready));

  // A stalled output keeps its word
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(operand_valid_o && !operand_ready_i) |->
      (operand_valid_o && operand_o == $past(operand_o)))
    else value_mismatch("operand_o", $sampled(operand_o), $past(operand_o));

  a_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!operand_valid_o && operand_queue_ready_o))
    else report_failure("valid or ready wrong while in reset");

  ////////////////////
  // Tests
  ////////////////////

  initial begin : stimulus
    int    err0;
    word_t w0, w1;
    clk_i            = 1'b0;
    rst_ni           = 1'b1;
    lane_id_i        = '0;
    cmd_i            = '0;
    cmd_valid_i      = 1'b0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    operand_ready_i  = 1'b1;
    bp_en            = 1'b0;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    #1 rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #2 rst_ni = 1'b1;

    err0 = errors;
    assert (!operand_valid_o) else report_failure("operand_valid_o high after reset");
    assert (operand_queue_ready_o) else report_failure("operand_queue_ready_o low after reset");
    finish_test("reset state", err0);

    err0 = errors;
    run_cmd(make_cmd(ConvNone, EW8, 2'd0, FuSlide, `OPQ_VL_W'(16)));
    drain();
    run_cmd(make_cmd(ConvNone, EW8, 2'd0, FuAddrGen, `OPQ_VL_W'(16)));
    drain();
    finish_test("pass-through", err0);

    // Two words worth of elements for every pairing that fits
    err0 = errors;
    for (int c = SExt2; c <= ZExt8; c++) begin
      for (int e = 0; e < 4; e++) begin
        if ((8 << e) * widen_factor(conv_e'(c)) <= 64) begin
          run_cmd(make_cmd(conv_e'(c), eew_e'(e), 2'd0, FuSlide, `OPQ_VL_W'(128 / (8 << e))));
          drain();
        end
      end
    end
    finish_test("extensions", err0);

    err0 = errors;
    for (int lane = 0; lane < 4; lane += 2) begin
      lane_id_i = `OPQ_LANE_W'(lane);
      for (int ntr = 0; ntr < 4; ntr++) begin
        for (int e = 0; e < 4; e++) begin
          run_cmd(make_cmd(IntRedZExt, eew_e'(e), 2'(ntr), FuSlide, `OPQ_VL_W'(2)));
          drain();
        end
      end
    end
    lane_id_i = '0;
    finish_test("reduction", err0);

    err0 = errors;
    repeat (2) begin
      run_cmd(make_cmd(WideFP2, EW16, 2'd0, FuSlide, `OPQ_VL_W'(8)));
      drain();
      run_cmd(make_cmd(WideFP2, EW32, 2'd0, FuSlide, `OPQ_VL_W'(4)));
      drain();
    end
    finish_test("fp widening", err0);

    // Use up all credits before any word arrives
    err0 = errors;
    w0   = {$random(seed), $random(seed)};
    w1   = {$random(seed), $random(seed)};
    repeat (`OPQ_BUF_DEPTH) issue_pulse();
    assert (!operand_queue_ready_o) else report_failure("ready still high with no credit left");
    send_word(w0, 1'b0);
    send_word(w1, 1'b0);
    exp_q.push_back('{word: w0, fu: FuAddrGen, pops: 1'b1});
    push_cmd(make_cmd(ConvNone, EW64, 2'd0, FuAddrGen, `OPQ_VL_W'(1)));
    drain();
    assert (operand_queue_ready_o) else report_failure("ready did not return after a pop");
    exp_q.push_back('{word: w1, fu: FuAddrGen, pops: 1'b1});
    push_cmd(make_cmd(ConvNone, EW64, 2'd0, FuAddrGen, `OPQ_VL_W'(1)));
    drain();
    bp_en = 1'b1;
    run_cmd(make_cmd(SExt4, EW8, 2'd0, FuAddrGen, `OPQ_VL_W'(16)));
    run_cmd(make_cmd(ZExt2, EW16, 2'd0, FuSlide, `OPQ_VL_W'(8)));
    drain();
    bp_en = 1'b0;
    finish_test("credit and back-pressure", err0);

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run still busy after %0d cycles", cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: source/operand_queue.sv
// Operand queue of one lane; lane_id_i is expected static while a reduction is in flight
`include "opq_defines.svh"

module operand_queue
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`OPQ_LANE_W-1:0] lane_id_i,
  // Operand requester
  input  opq_cmd_t               cmd_i,
  input  logic                   cmd_valid_i,
  output logic                   operand_queue_ready_o,
  // Register file
  input  word_t                  operand_i,
  input  logic                   operand_valid_i,
  input  logic                   operand_issued_i,
  // Functional unit
  output word_t                  operand_o,
  output target_fu_e             target_fu_o,
  output logic                   operand_valid_o,
  input  logic                   operand_ready_i
);

  opq_head_t  head;
  word_t      head_word;
  logic [2:0] pass_idx;
  logic       word_pop, cmd_pop;

  opq_input_stage input_stage_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .cmd_i                 (cmd_i),
    .cmd_valid_i           (cmd_valid_i),
    .operand_i             (operand_i),
    .operand_valid_i       (operand_valid_i),
    .operand_issued_i      (operand_issued_i),
    .word_pop_i            (word_pop),
    .cmd_pop_i             (cmd_pop),
    .head_o                (head),
    .head_word_o           (head_word),
    .operand_queue_ready_o (operand_queue_ready_o)
  );

  opq_convert convert_i (
    .head_i      (head),
    .head_word_i (head_word),
    .pass_idx_i  (pass_idx),
    .lane_id_i   (lane_id_i),
    .conv_word_o (operand_o)
  );

  opq_sequencer sequencer_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .head_i          (head),
    .operand_ready_i (operand_ready_i),
    .operand_valid_o (operand_valid_o),
    .pass_idx_o      (pass_idx),
    .word_pop_o      (word_pop),
    .cmd_pop_o       (cmd_pop)
  );

  assign target_fu_o = head.cmd.target_fu;

endmodule

// File: source/opq_sequencer.sv
// Output needs both a command and a word; a vl of zero still retires after one transfer
`include "opq_defines.svh"

module opq_sequencer
  import opq_cmd_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  opq_head_t head_i,
  input  logic      operand_ready_i,
  output logic      operand_valid_o,
  output logic [2:0] pass_idx_o,
  output logic      word_pop_o,
  output logic      cmd_pop_o
);

  logic [`OPQ_VL_W-1:0] cnt_q, cnt_d;
  logic [`OPQ_VL_W-1:0] inc;
  logic [`OPQ_VL_W:0]   cnt_sum;
  logic [2:0]           pass_q, pass_d;
  logic [1:0]           f_lg;
  logic                 fire, last_pass;

  assign operand_valid_o = head_i.cmd_valid & head_i.word_valid;
  assign fire            = operand_valid_o & operand_ready_i;
  assign pass_idx_o      = pass_q;

  assign f_lg      = ext_factor_lg(head_i.cmd);
  // For F = 8 the shift wraps to 0 and the minus one gives 7
  assign last_pass = (pass_q == ((3'd1 << f_lg) - 3'd1));

  ////////////////////
  // Element count
  ////////////////////

  always_comb begin
    if (head_i.cmd.conv == IntRedZExt) begin
      inc = `OPQ_VL_W'(1);
    end else begin
      // 64/eew elements per word, spread over F passes
      inc = `OPQ_VL_W'(4'd8 >> ({1'b0, head_i.cmd.eew} + {1'b0, f_lg}));
    end
  end

  assign cnt_sum = {1'b0, cnt_q} + {1'b0, inc};

  always_comb begin
    pass_d     = pass_q;
    cnt_d      = cnt_q;
    word_pop_o = 1'b0;
    cmd_pop_o  = 1'b0;
    if (fire) begin
      if (cnt_sum >= {1'b0, head_i.cmd.vl}) begin
        // Command done, drop whatever is left of the word
        word_pop_o = 1'b1;
        cmd_pop_o  = 1'b1;
        pass_d     = '0;
        cnt_d      = '0;
      end else begin
        cnt_d = cnt_sum[`OPQ_VL_W-1:0];
        if (last_pass) begin
          word_pop_o = 1'b1;
          pass_d     = '0;
        end else begin
          pass_d = pass_q + 3'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      pass_q <= '0;
    end else begin
      cnt_q  <= cnt_d;
      pass_q <= pass_d;
    end
  end

endmodule

// File: source/opq_convert.sv
// Zero-latency conversion; fp widening is exact for normal inputs only, no subnormal, inf or NaN care
`include "opq_defines.svh"

module opq_convert
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
(
  input  opq_head_t             head_i,
  input  word_t                 head_word_i,
  input  logic [2:0]            pass_idx_i,
  input  logic [`OPQ_LANE_W-1:0] lane_id_i,
  output word_t                 conv_word_o
);

  ////////////////////
  // Helpers
  ////////////////////

  // Widen the pass-th block of 64/F bits into elements of F times the width
  function automatic word_t extend_word(word_t w, eew_e eew, logic [1:0] f_lg,
                                        logic [2:0] pass, logic sgn);
    word_t       res;
    int unsigned src_lg, dst_lg, blk_lg, off, base, idx;
    src_lg = 3 + int'(eew);
    dst_lg = src_lg + int'(f_lg);
    blk_lg = 6 - int'(f_lg);
    res    = '0;
    for (int unsigned b = 0; b < `OPQ_WORD_W; b++) begin
      off  = b & ((1 << dst_lg) - 1);
      base = (int'(pass) << blk_lg) + ((b >> dst_lg) << src_lg);
      // Above the source width every bit copies the source MSB
      idx  = (off < (1 << src_lg)) ? base + off : base + (1 << src_lg) - 1;
      if (off < (1 << src_lg)) begin
        res[b] = w[idx[5:0]];
      end else begin
        res[b] = sgn & w[idx[5:0]];
      end
    end
    return res;
  endfunction

  // Neutral element is ntr[1] on top and ntr[0] below
  function automatic word_t reduce_word(word_t w, eew_e eew, logic [1:0] ntr, logic lane0);
    word_t       res;
    int unsigned ew;
    ew  = 8 << int'(eew);
    res = '0;
    for (int unsigned b = 0; b < `OPQ_WORD_W; b++) begin
      if (lane0 && (b < ew)) begin
        res[b] = w[b];
      end else if ((b & (ew - 1)) == (ew - 1)) begin
        res[b] = ntr[1];
      end else begin
        res[b] = ntr[0];
      end
    end
    return res;
  endfunction

  ////////////////////
  // Conversion
  ////////////////////

  always_comb begin : p_convert
    word_t      res;
    fp_word_u   src, dst;
    fp16_t      h;
    fp32_t      f, hw;
    fp64_t      fw;
    logic [1:0] f_lg;
    logic       sel;

    res  = head_word_i;
    src  = head_word_i;
    dst  = '0;
    h    = '0;
    f    = '0;
    hw   = '0;
    fw   = '0;
    f_lg = ext_factor_lg(head_i.cmd);
    // Lower or upper half of the word for the fp case
    sel  = pass_idx_i[0];

    case (head_i.cmd.conv)
      SExt2, SExt4, SExt8: begin
        if (f_lg != 2'd0) begin
          res = extend_word(head_word_i, head_i.cmd.eew, f_lg, pass_idx_i, 1'b1);
        end
      end
      ZExt2, ZExt4, ZExt8: begin
        if (f_lg != 2'd0) begin
          res = extend_word(head_word_i, head_i.cmd.eew, f_lg, pass_idx_i, 1'b0);
        end
      end
      IntRedZExt: begin
        res = reduce_word(head_word_i, head_i.cmd.eew, head_i.cmd.ntr_red, lane_id_i == '0);
      end
      WideFP2: begin
        if (head_i.cmd.eew == EW16) begin
          for (int e = 0; e < 2; e++) begin
            h        = src.h[2 * sel + e];
            hw.s     = h.s;
            // Bias 15 to bias 127
            hw.e     = {3'b000, h.e} + 8'd112;
            hw.m     = {h.m, 13'b0};
            dst.f[e] = hw;
          end
          res = dst;
        end else if (head_i.cmd.eew == EW32) begin
          f    = src.f[sel];
          fw.s = f.s;
          // Bias 127 to bias 1023
          fw.e = {3'b000, f.e} + 11'd896;
          fw.m = {f.m, 29'b0};
          res  = fw;
        end
      end
      default: begin
        res = head_word_i;
      end
    endcase

    conv_word_o = res;
  end

endmodule

// File: source/opq_input_stage.sv
// Requester must only issue reads while ready is high, otherwise words are dropped at the full FIFO
`include "opq_defines.svh"

module opq_input_stage
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  opq_cmd_t  cmd_i,
  input  logic      cmd_valid_i,
  input  word_t     operand_i,
  input  logic      operand_valid_i,
  input  logic      operand_issued_i,
  input  logic      word_pop_i,
  input  logic      cmd_pop_i,
  output opq_head_t head_o,
  output word_t     head_word_o,
  output logic      operand_queue_ready_o
);

  localparam int unsigned USE_W = $clog2(`OPQ_BUF_DEPTH + 1);

  opq_cmd_t         cmd_head;
  logic             cmd_empty, word_empty;
  logic [USE_W-1:0] usage_q;

  ////////////////////
  // Command FIFO
  ////////////////////

  opq_fifo #(
    .DEPTH (`OPQ_BUF_DEPTH),
    .WIDTH ($bits(opq_cmd_t))
  ) cmd_fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_valid_i),
    .data_i  (cmd_i),
    .pop_i   (cmd_pop_i),
    .data_o  (cmd_head),
    .empty_o (cmd_empty),
    .full_o  ()
  );

  ////////////////////
  // Operand FIFO
  ////////////////////

  opq_fifo #(
    .DEPTH (`OPQ_BUF_DEPTH),
    .WIDTH (`OPQ_WORD_W)
  ) word_fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (operand_valid_i),
    .data_i  (operand_i),
    .pop_i   (word_pop_i),
    .data_o  (head_word_o),
    .empty_o (word_empty),
    .full_o  ()
  );

  assign head_o.cmd        = cmd_head;
  assign head_o.cmd_valid  = ~cmd_empty;
  assign head_o.word_valid = ~word_empty;

  // Credits count reads in flight plus words still buffered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      usage_q <= '0;
    end else begin
      case ({operand_issued_i, word_pop_i})
        2'b10:   usage_q <= usage_q + 1'b1;
        2'b01:   usage_q <= usage_q - 1'b1;
        default: usage_q <= usage_q;
      endcase
    end
  end

  assign operand_queue_ready_o = (usage_q < USE_W'(`OPQ_BUF_DEPTH));

endmodule

// File: source/opq_fifo.sv
// Fall-through FIFO; a push while full and a pop while empty are dropped, no simultaneous bypass
module opq_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push, do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head is visible without a read cycle
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: source/opq_cmd_pkg.sv
// Command format from the operand requester; extension factor is 1 for every unsupported pairing
`include "opq_defines.svh"

package opq_cmd_pkg;
  import opq_elem_pkg::*;

  typedef enum logic [3:0] {
    ConvNone,
    SExt2,
    SExt4,
    SExt8,
    ZExt2,
    ZExt4,
    ZExt8,
    IntRedZExt,
    WideFP2
  } conv_e;

  // Slide unit is the default destination
  typedef enum logic {
    FuSlide   = 1'b0,
    FuAddrGen = 1'b1
  } target_fu_e;

  typedef struct packed {
    conv_e                conv;
    eew_e                 eew;
    logic [1:0]           ntr_red;
    target_fu_e           target_fu;
    logic [`OPQ_VL_W-1:0] vl;
  } opq_cmd_t;

  // Head of both FIFOs, as seen by the later stages
  typedef struct packed {
    opq_cmd_t cmd;
    logic     cmd_valid;
    logic     word_valid;
  } opq_head_t;

  // Log2 of the widening factor; 0 when the widened element would not fit
  function automatic logic [1:0] ext_factor_lg(opq_cmd_t cmd);
    logic [1:0] f_lg;
    case (cmd.conv)
      SExt2, ZExt2: f_lg = 2'd1;
      SExt4, ZExt4: f_lg = 2'd2;
      SExt8, ZExt8: f_lg = 2'd3;
      WideFP2:      f_lg = (cmd.eew inside {EW16, EW32}) ? 2'd1 : 2'd0;
      default:      f_lg = 2'd0;
    endcase
    if (({1'b0, f_lg} + {1'b0, cmd.eew}) > 3'd3) begin
      f_lg = 2'd0;
    end
    return f_lg;
  endfunction

endpackage

// File: source/opq_elem_pkg.sv
// Element formats of one operand word; fp types follow IEEE 754 binary16, binary32, binary64
`include "opq_defines.svh"

package opq_elem_pkg;

  ////////////////////
  // Element width
  ////////////////////

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  ////////////////////
  // Floating point
  ////////////////////

  typedef struct packed {
    logic       s;
    logic [4:0] e;
    logic [9:0] m;
  } fp16_t;

  typedef struct packed {
    logic        s;
    logic [7:0]  e;
    logic [22:0] m;
  } fp32_t;

  typedef struct packed {
    logic        s;
    logic [10:0] e;
    logic [51:0] m;
  } fp64_t;

  // Same word, seen as four halves or as two singles
  typedef union packed {
    fp16_t [3:0] h;
    fp32_t [1:0] f;
  } fp_word_u;

  typedef logic [`OPQ_WORD_W-1:0] word_t;

endpackage

// File: source/opq_defines.svh
// Sizes shared by all stages; buffer depth must be at least 1 and the word is fixed at 64 bits
`ifndef OPQ_DEFINES_SVH
`define OPQ_DEFINES_SVH

////////////////////
// Datapath
////////////////////

// Operand word coming from the register file
`define OPQ_WORD_W 64

////////////////////
// Buffering and control
////////////////////

// Entries in both the command FIFO and the operand FIFO
`define OPQ_BUF_DEPTH 2
// Vector length and element counters
`define OPQ_VL_W 16
// Lane index
`define OPQ_LANE_W 2

`endif
